/* logic/ppu_timing_pkg.sv */
package ppu_timing_pkg;

    // raster geometry, counted in dots and scanlines
    localparam int raster_dots_per_line = 341;
    localparam int raster_last_line     = 260;     // last line of vertical blank

    // pre-render line is the all-ones line number
    localparam logic [8:0] raster_prerender_line = 9'h1ff;
    localparam logic [8:0] raster_vblank_line    = 9'd240;

    localparam int raster_visible_dots = 256;

    // the next line's first two tiles are fetched inside this window
    localparam int raster_prefetch_first = 320;
    localparam int raster_prefetch_end   = 336;

    // each tile takes four two-dot fetch slots
    typedef enum logic [1:0] {
        fetch_nametable  = 2'd0,
        fetch_attribute  = 2'd1,
        fetch_pattern_lo = 2'd2,
        fetch_pattern_hi = 2'd3
    } fetch_phase_t;

endpackage

/* logic/ppu_reg_pkg.sv */
package ppu_reg_pkg;

    // register number on the cpu bus
    typedef enum logic [2:0] {
        reg_ctrl     = 3'd0,
        reg_mask     = 3'd1,
        reg_status   = 3'd2,
        reg_oam_addr = 3'd3,    // decoded, no object memory behind it
        reg_oam_data = 3'd4,
        reg_scroll   = 3'd5,
        reg_addr     = 3'd6,
        reg_data     = 3'd7
    } ppu_reg_t;

    // control register bits
    localparam int ctrl_inc32_bit    = 2;   // data port steps by 32 instead of 1
    localparam int ctrl_bg_table_bit = 4;   // background pattern table
    localparam int ctrl_nmi_bit      = 7;

    // rendering is on when either of these is set
    localparam int mask_render_lo = 3;
    localparam int mask_render_hi = 4;

    localparam logic [5:0] palette_page = 6'h3f;    // 3F00 and up

endpackage

/* logic/ppu_timing.sv */
`timescale 1ns/1ps

module ppu_timing
    import ppu_timing_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       rendering_on,
    input  logic       status_read,
    output logic [8:0] cycle,
    output logic [8:0] scanline,
    output logic       vblank,
    output logic       render_line
);

    logic odd_frame;
    logic line_end;
    logic frame_end;

    // odd frames drop the last dot of the pre-render line while rendering
    assign line_end = (odd_frame && rendering_on && scanline == raster_prerender_line) ?
                      (cycle == raster_dots_per_line - 2) :
                      (cycle == raster_dots_per_line - 1);

    assign frame_end = line_end && (scanline == raster_last_line);

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle     <= 9'd0;
            scanline  <= 9'd0;
            odd_frame <= 1'b0;
            vblank    <= 1'b1;
        end else begin
            cycle <= line_end ? 9'd0 : cycle + 9'd1;
            if (line_end) begin
                // 511 + 1 rolls over to line 0
                scanline <= frame_end ? raster_prerender_line : scanline + 9'd1;
            end
            if (frame_end) begin
                odd_frame <= ~odd_frame;
            end

            if (line_end && scanline == raster_vblank_line) begin
                vblank <= 1'b1;
            end else if (frame_end || status_read) begin
                vblank <= 1'b0;
            end
        end
    end

    // lines that fetch background tiles
    assign render_line = rendering_on && !vblank && (scanline != raster_vblank_line);

    a_cycle_range: assert property (
        @(posedge clk) disable iff (reset)
        cycle <= raster_dots_per_line - 1
    ) else $error("dot counter passed the end of the line: %0d", cycle);

endmodule

/* logic/ppu_regs.sv */
`timescale 1ns/1ps

module ppu_regs
    import ppu_reg_pkg::*;
#(
    parameter int vram_addr_w = 14
) (
    input  logic                   clk,
    input  logic                   reset,
    input  ppu_reg_t               ain,
    input  logic [7:0]             din,
    input  logic                   read,
    input  logic                   write,
    input  logic                   vblank,
    output logic [7:0]             dout,
    output logic [7:0]             ctrl,
    output logic [7:0]             mask,
    output logic [15:0]            scroll,
    output logic [vram_addr_w-1:0] cpu_addr,
    output logic                   cpu_access,
    output logic                   status_read,
    output logic                   vram_w,
    output logic                   cpu_vram_r,
    output logic                   pal_we,
    output logic [4:0]             pal_index,
    output logic [5:0]             pal_data
);

    logic                   w_toggle;   // first or second byte of scroll and addr
    logic [vram_addr_w-1:0] addr;
    logic [vram_addr_w-1:0] addr_step;
    logic                   in_palette;

    assign addr_step  = ctrl[ctrl_inc32_bit] ? vram_addr_w'(32) : vram_addr_w'(1);
    assign in_palette = (addr[vram_addr_w-1 -: 6] == palette_page);

    assign cpu_access  = (ain == reg_data) && (read || write);
    assign cpu_addr    = addr;
    assign cpu_vram_r  = (ain == reg_data) && read;
    assign status_read = (ain == reg_status) && read;

    // data port writes go either to vram or to the palette
    assign vram_w    = (ain == reg_data) && write && !in_palette;
    assign pal_we    = (ain == reg_data) && write && in_palette;
    assign pal_index = addr[4:0];
    assign pal_data  = din[5:0];

    assign dout = status_read ? {vblank, 7'd0} : 8'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl     <= 8'd0;
            mask     <= 8'd0;
            scroll   <= 16'd0;
            addr     <= '0;
            w_toggle <= 1'b0;
        end else begin
            if (write) begin
                case (ain)
                    reg_ctrl: ctrl <= din;
                    reg_mask: mask <= din;
                    reg_scroll: begin
                        if (!w_toggle) begin
                            scroll[15:8] <= din;    // x first
                        end else begin
                            scroll[7:0] <= din;
                        end
                        w_toggle <= ~w_toggle;
                    end
                    reg_addr: begin
                        if (!w_toggle) begin
                            addr[vram_addr_w-1:8] <= din[vram_addr_w-9:0];
                        end else begin
                            addr[7:0] <= din;
                        end
                        w_toggle <= ~w_toggle;
                    end
                    reg_status, reg_oam_addr, reg_oam_data, reg_data: ;
                endcase
            end
            if (cpu_access) begin
                addr <= addr + addr_step;   // auto-increment after each data access
            end
            if (status_read) begin
                w_toggle <= 1'b0;
            end
        end
    end

    a_one_target: assert property (
        @(posedge clk) disable iff (reset)
        !(vram_w && pal_we)
    ) else $error("data port write went to vram and palette at once");

endmodule

/* logic/ppu_bg_fetch.sv */
`timescale 1ns/1ps

module ppu_bg_fetch
    import ppu_timing_pkg::*;
    import ppu_reg_pkg::*;
#(
    parameter int vram_addr_w = 14
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [8:0]             cycle,
    input  logic [8:0]             scanline,
    input  logic                   render_line,
    input  logic [7:0]             ctrl,
    input  logic [15:0]            scroll,
    input  logic [vram_addr_w-1:0] cpu_addr,
    input  logic                   cpu_access,
    input  logic [7:0]             vram_din,
    output logic [vram_addr_w-1:0] vram_a,
    output logic                   bg_vram_r,
    output logic                   tile_load,
    output logic [7:0]             pat_lo,
    output logic [7:0]             pat_hi,
    output logic [1:0]             attr
);

    logic [4:0]             coarse_x;
    logic [2:0]             fine_x;
    logic [7:0]             scroll_y;
    logic [1:0]             nt_sel;     // nametable, bit 0 horizontal
    logic [7:0]             nt_byte;
    logic [8:0]             cyc_m1;
    fetch_phase_t           slot;
    logic                   in_fetch;
    logic [vram_addr_w-1:0] bg_a;

    assign cyc_m1   = cycle - 9'd1;
    assign slot     = fetch_phase_t'(cyc_m1[2:1]);
    assign in_fetch = (cycle >= 9'd1 && cycle <= raster_visible_dots) ||
                      (cycle > raster_prefetch_first && cycle <= raster_prefetch_end);

    always_comb begin
        case (slot)
            fetch_nametable:
                bg_a = vram_addr_w'({2'b10, nt_sel, scroll_y[7:3], coarse_x});
            fetch_attribute:
                bg_a = vram_addr_w'({2'b10, nt_sel, 4'b1111, scroll_y[7:5], coarse_x[4:2]});
            fetch_pattern_lo:
                bg_a = vram_addr_w'({1'b0, ctrl[ctrl_bg_table_bit], nt_byte, 1'b0, scroll_y[2:0]});
            fetch_pattern_hi:
                bg_a = vram_addr_w'({1'b0, ctrl[ctrl_bg_table_bit], nt_byte, 1'b1, scroll_y[2:0]});
        endcase
    end

    // cpu data port wins the bus
    assign vram_a    = cpu_access ? cpu_addr : bg_a;
    assign bg_vram_r = render_line && in_fetch && cycle[0] && !cpu_access;

    always_ff @(posedge clk) begin
        if (reset) begin
            coarse_x <= 5'd0;
            fine_x   <= 3'd0;
            scroll_y <= 8'd0;
            nt_sel   <= 2'd0;
        end else if (render_line) begin
            if (in_fetch) begin
                fine_x <= fine_x + 3'd1;
                if (fine_x == 3'd7) begin
                    coarse_x <= coarse_x + 5'd1;
                    if (coarse_x == 5'd31) begin
                        nt_sel[0] <= ~nt_sel[0];    // wrap into the next nametable
                    end
                end
            end
            if (cycle == 9'd251) begin
                if (scroll_y == raster_vblank_line - 1) begin
                    scroll_y  <= 8'd0;
                    nt_sel[1] <= ~nt_sel[1];
                end else begin
                    scroll_y <= scroll_y + 8'd1;
                end
            end
            if (cycle == raster_prefetch_first) begin
                coarse_x  <= scroll[15:11];
                fine_x    <= scroll[10:8];
                nt_sel[0] <= ctrl[0];
            end
            // full reload ahead of the frame
            if (scanline == raster_prerender_line && cycle == raster_prefetch_first - 1) begin
                coarse_x <= scroll[15:11];
                fine_x   <= scroll[10:8];
                scroll_y <= scroll[7:0];
                nt_sel   <= ctrl[1:0];
            end
        end
    end

    // vram_din answers the read of the previous dot
    always_ff @(posedge clk) begin
        if (render_line && in_fetch && !cycle[0]) begin
            case (slot)
                fetch_nametable:  nt_byte <= vram_din;
                fetch_attribute:  attr <= vram_din[{scroll_y[4], coarse_x[1], 1'b0} +: 2];
                fetch_pattern_lo: pat_lo <= vram_din;
                fetch_pattern_hi: pat_hi <= vram_din;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tile_load <= 1'b0;
        end else begin
            tile_load <= render_line && in_fetch && !cycle[0] && (slot == fetch_pattern_hi);
        end
    end

endmodule

/* logic/ppu_bg_shifter.sv */
`timescale 1ns/1ps

module ppu_bg_shifter
    import ppu_timing_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [8:0] cycle,
    input  logic       tile_load,
    input  logic [7:0] pat_lo,
    input  logic [7:0] pat_hi,
    input  logic [1:0] attr,
    output logic [3:0] pixel_index
);

    logic [15:0] pat_lo_sr;
    logic [15:0] pat_hi_sr;
    logic [7:0]  attr_lo_sr;
    logic [7:0]  attr_hi_sr;
    logic [1:0]  attr_q;        // serial feed for the attribute shifters
    logic        shift_en;

    // leftmost pixel is bit 7 of a pattern byte and leaves the shifter first
    function automatic logic [7:0] bit_rev(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

    // shifting trails the fetch window by one dot, tile_load lands on the group boundary
    assign shift_en = (cycle > 9'd1 && cycle <= raster_visible_dots + 1) ||
                      (cycle > raster_prefetch_first + 1 && cycle <= raster_prefetch_end + 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            pat_lo_sr  <= 16'd0;
            pat_hi_sr  <= 16'd0;
            attr_lo_sr <= 8'd0;
            attr_hi_sr <= 8'd0;
            attr_q     <= 2'd0;
        end else if (shift_en) begin
            if (tile_load) begin
                pat_lo_sr <= {bit_rev(pat_lo), pat_lo_sr[8:1]};  // next tile into the top half
                pat_hi_sr <= {bit_rev(pat_hi), pat_hi_sr[8:1]};
                attr_q    <= attr;
            end else begin
                pat_lo_sr <= {1'b0, pat_lo_sr[15:1]};
                pat_hi_sr <= {1'b0, pat_hi_sr[15:1]};
            end
            attr_lo_sr <= {attr_q[0], attr_lo_sr[7:1]};
            attr_hi_sr <= {attr_q[1], attr_hi_sr[7:1]};
        end
    end

    assign pixel_index = {attr_hi_sr[0], attr_lo_sr[0], pat_hi_sr[0], pat_lo_sr[0]};

endmodule

/* logic/ppu_palette.sv */
`timescale 1ns/1ps

module ppu_palette #(
    parameter int palette_depth = 32
) (
    input  logic       clk,
    input  logic       pal_we,
    input  logic [4:0] pal_index,
    input  logic [5:0] pal_data,
    input  logic [3:0] pixel_index,
    output logic [5:0] color
);

    logic [5:0] pal_mem [palette_depth];
    logic       mirror_slot;

    // entries 4, 8 and 12 of each half mirror the backdrop and keep no value
    assign mirror_slot = (pal_index[1:0] == 2'b00) && (pal_index[3:2] != 2'b00);

    always_ff @(posedge clk) begin
        if (pal_we && !mirror_slot) begin
            pal_mem[pal_index] <= pal_data;
        end
    end

    // background uses the lower half only
    always_ff @(posedge clk) begin
        color <= pal_mem[{1'b0, pixel_index}];
    end

endmodule

/* logic/ppu_top.sv */
`timescale 1ns/1ps

module ppu_top
    import ppu_reg_pkg::*;
#(
    parameter int vram_addr_w   = 14,
    parameter int palette_depth = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  ppu_reg_t               ain,
    input  logic [7:0]             din,
    input  logic                   read,
    input  logic                   write,
    output logic [7:0]             dout,
    output logic                   nmi,
    output logic                   vram_r,
    output logic                   vram_w,
    output logic [vram_addr_w-1:0] vram_a,
    input  logic [7:0]             vram_din,
    output logic [7:0]             vram_dout,
    output logic [8:0]             scanline,
    output logic [8:0]             cycle,
    output logic [5:0]             color
);

    logic                   vblank;
    logic                   render_line;
    logic                   rendering_on;
    logic                   status_read;
    logic [7:0]             ctrl;
    logic [7:0]             mask;
    logic [15:0]            scroll;
    logic [vram_addr_w-1:0] cpu_addr;
    logic                   cpu_access;
    logic                   cpu_vram_r;
    logic                   bg_vram_r;
    logic                   pal_we;
    logic [4:0]             pal_index;
    logic [5:0]             pal_data;
    logic                   tile_load;
    logic [7:0]             pat_lo;
    logic [7:0]             pat_hi;
    logic [1:0]             attr;
    logic [3:0]             pixel_index;

    assign rendering_on = mask[mask_render_lo] | mask[mask_render_hi];
    assign nmi          = vblank && ctrl[ctrl_nmi_bit];
    assign vram_r       = bg_vram_r | cpu_vram_r;
    assign vram_dout    = din;      // data port writes go straight out

    ppu_timing i_ppu_timing (
        .clk          (clk),
        .reset        (reset),
        .rendering_on (rendering_on),
        .status_read  (status_read),
        .cycle        (cycle),
        .scanline     (scanline),
        .vblank       (vblank),
        .render_line  (render_line)
    );

    ppu_regs #(
        .vram_addr_w (vram_addr_w)
    ) i_ppu_regs (
        .clk         (clk),
        .reset       (reset),
        .ain         (ain),
        .din         (din),
        .read        (read),
        .write       (write),
        .vblank      (vblank),
        .dout        (dout),
        .ctrl        (ctrl),
        .mask        (mask),
        .scroll      (scroll),
        .cpu_addr    (cpu_addr),
        .cpu_access  (cpu_access),
        .status_read (status_read),
        .vram_w      (vram_w),
        .cpu_vram_r  (cpu_vram_r),
        .pal_we      (pal_we),
        .pal_index   (pal_index),
        .pal_data    (pal_data)
    );

    ppu_bg_fetch #(
        .vram_addr_w (vram_addr_w)
    ) i_ppu_bg_fetch (
        .clk         (clk),
        .reset       (reset),
        .cycle       (cycle),
        .scanline    (scanline),
        .render_line (render_line),
        .ctrl        (ctrl),
        .scroll      (scroll),
        .cpu_addr    (cpu_addr),
        .cpu_access  (cpu_access),
        .vram_din    (vram_din),
        .vram_a      (vram_a),
        .bg_vram_r   (bg_vram_r),
        .tile_load   (tile_load),
        .pat_lo      (pat_lo),
        .pat_hi      (pat_hi),
        .attr        (attr)
    );

    ppu_bg_shifter i_ppu_bg_shifter (
        .clk         (clk),
        .reset       (reset),
        .cycle       (cycle),
        .tile_load   (tile_load),
        .pat_lo      (pat_lo),
        .pat_hi      (pat_hi),
        .attr        (attr),
        .pixel_index (pixel_index)
    );

    ppu_palette #(
        .palette_depth (palette_depth)
    ) i_ppu_palette (
        .clk         (clk),
        .pal_we      (pal_we),
        .pal_index   (pal_index),
        .pal_data    (pal_data),
        .pixel_index (pixel_index),
        .color       (color)
    );

endmodule

/* verification/ppu_tb.sv */
`timescale 1ns/1ps

module ppu_tb
    import ppu_reg_pkg::*;
();

    localparam int wait_limit = 100000;    // a bit more than one frame

    logic        clk;
    logic        reset;
    ppu_reg_t    ain;
    logic [7:0]  din;
    logic        read;
    logic        write;
    logic [7:0]  dout;
    logic        nmi;
    logic        vram_r;
    logic        vram_w;
    logic [13:0] vram_a;
    logic [7:0]  vram_din;
    logic [7:0]  vram_dout;
    logic [8:0]  scanline;
    logic [8:0]  cycle;
    logic [5:0]  color;

    // reference raster and register state
    logic [8:0]  exp_cycle;
    logic [8:0]  exp_line;
    logic        exp_odd;
    logic        exp_vblank;
    logic        exp_render;
    logic        exp_nmi_en;
    logic        exp_last;
    logic [7:0]  exp_dout;

    logic [13:0] want_addr;     // address the next data port write should hit
    logic [13:0] addr_step;
    logic [5:0]  pal0;
    logic [5:0]  pal1;
    logic        pal_check;
    logic        bg_check;
    logic        req_q;
    logic [13:0] addr_q;
    logic [31:0] rnd;
    integer      seed;

    ppu_top #(
        .vram_addr_w   (14),
        .palette_depth (32)
    ) i_ppu_top (
        .clk       (clk),
        .reset     (reset),
        .ain       (ain),
        .din       (din),
        .read      (read),
        .write     (write),
        .dout      (dout),
        .nmi       (nmi),
        .vram_r    (vram_r),
        .vram_w    (vram_w),
        .vram_a    (vram_a),
        .vram_din  (vram_din),
        .vram_dout (vram_dout),
        .scanline  (scanline),
        .cycle     (cycle),
        .color     (color)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // short pre-render line on odd frames while rendering
    assign exp_last = (exp_line == 9'd511 && exp_odd && exp_render) ? (exp_cycle == 9'd339) :
                                                                       (exp_cycle == 9'd340);

    // status shows vblank in bit 7, every other read gives zero
    assign exp_dout = (read && ain == reg_status) ? {exp_vblank, 7'd0} : 8'd0;

    always @(posedge clk) begin
        if (reset) begin
            exp_cycle  <= 9'd0;
            exp_line   <= 9'd0;
            exp_odd    <= 1'b0;
            exp_vblank <= 1'b1;
            exp_render <= 1'b0;
            exp_nmi_en <= 1'b0;
        end else begin
            exp_cycle <= exp_last ? 9'd0 : exp_cycle + 9'd1;
            if (exp_last && exp_line == 9'd260) begin
                exp_line <= 9'd511;
                exp_odd  <= ~exp_odd;
            end else if (exp_last) begin
                exp_line <= exp_line + 9'd1;    // 511 rolls over to 0
            end
            if (exp_last && exp_line == 9'd240) begin
                exp_vblank <= 1'b1;
            end else if ((exp_last && exp_line == 9'd260) || (read && ain == reg_status)) begin
                exp_vblank <= 1'b0;
            end
            if (write && ain == reg_mask) begin
                exp_render <= din[mask_render_lo] | din[mask_render_hi];
            end
            if (write && ain == reg_ctrl) begin
                exp_nmi_en <= din[ctrl_nmi_bit];
            end
        end
    end

    // vram model, pattern low plane reads all ones and everything else zero
    function automatic logic [7:0] vram_byte(input logic [13:0] a);
        if (a < 14'h2000 && !a[3]) return 8'hff;
        return 8'h00;
    endfunction

    always @(negedge clk) begin
        req_q  <= vram_r;
        addr_q <= vram_a;
    end

    always @(posedge clk) begin
        vram_din <= #1 (req_q ? vram_byte(addr_q) : 8'h00);    // answer one clock later
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    a_raster: assert property (@(posedge clk) disable iff (reset)
        cycle == exp_cycle && scanline == exp_line)
        else stop_with_error($sformatf("Fail raster: expected %0d/%0d, actual %0d/%0d",
            $sampled(exp_line), $sampled(exp_cycle), $sampled(scanline), $sampled(cycle)));

    a_nmi: assert property (@(posedge clk) disable iff (reset)
        nmi == (exp_vblank && exp_nmi_en))
        else stop_with_error($sformatf("Fail nmi: expected %0b, actual %0b",
            $sampled(exp_vblank && exp_nmi_en), $sampled(nmi)));

    a_status: assert property (@(posedge clk) disable iff (reset)
        dout == exp_dout)
        else stop_with_error($sformatf("Fail status: expected %h, actual %h",
            $sampled(exp_dout), $sampled(dout)));

    a_vram_target: assert property (@(posedge clk) disable iff (reset)
        (write && ain == reg_data) |-> vram_w == (want_addr[13:8] != palette_page))
        else stop_with_error($sformatf("Fail vram_w: expected %0b, actual %0b",
            $sampled(want_addr[13:8] != palette_page), $sampled(vram_w)));

    a_vram_addr: assert property (@(posedge clk) disable iff (reset)
        vram_w |-> vram_a == want_addr)
        else stop_with_error($sformatf("Fail vram_a: expected %h, actual %h",
            $sampled(want_addr), $sampled(vram_a)));

    a_vram_data: assert property (@(posedge clk) disable iff (reset)
        vram_w |-> vram_dout == din)
        else stop_with_error($sformatf("Fail vram_dout: expected %h, actual %h",
            $sampled(din), $sampled(vram_dout)));

    a_palette: assert property (@(posedge clk) disable iff (reset)
        pal_check |-> color == pal0)
        else stop_with_error($sformatf("Fail palette: expected %h, actual %h",
            $sampled(pal0), $sampled(color)));

    a_fetch_read: assert property (@(posedge clk) disable iff (reset)
        (bg_check && exp_line <= 9'd239 && exp_cycle >= 9'd1 && exp_cycle <= 9'd256)
        |-> vram_r == exp_cycle[0])
        else stop_with_error($sformatf("Fail fetch read at dot %0d: expected %0b, actual %0b",
            $sampled(exp_cycle), $sampled(exp_cycle[0]), $sampled(vram_r)));

    a_bg_color: assert property (@(posedge clk) disable iff (reset)
        (bg_check && exp_line >= 9'd1 && exp_line <= 9'd239 &&
         exp_cycle >= 9'd8 && exp_cycle <= 9'd250) |-> color == pal1)
        else stop_with_error($sformatf("Fail background: expected %h, actual %h",
            $sampled(pal1), $sampled(color)));

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic cpu_write(input ppu_reg_t r, input logic [7:0] d);
        ain   = r;
        din   = d;
        write = 1'b1;
        next_cycle();
        write = 1'b0;
    endtask

    task automatic cpu_read(input ppu_reg_t r);
        ain  = r;
        read = 1'b1;
        next_cycle();
        read = 1'b0;
    endtask

    task automatic data_port_write(input logic [7:0] d);
        cpu_write(reg_data, d);
        want_addr = want_addr + addr_step;
    endtask

    task automatic set_vram_addr(input logic [13:0] a);
        cpu_read(reg_status);   // clears the write toggle
        cpu_write(reg_addr, {2'b00, a[13:8]});
        cpu_write(reg_addr, a[7:0]);
        want_addr = a;
    endtask

    task automatic wait_for_dot(input logic [8:0] line, input logic [8:0] dot);
        int n;
        n = 0;
        while (!(scanline == line && cycle == dot)) begin
            if (n >= wait_limit) begin
                stop_with_error($sformatf("timed out waiting for line %0d dot %0d", line, dot));
            end else begin
                n++;
                next_cycle();
            end
        end
    endtask

    initial begin
        seed      = 32'hcec1528d;
        reset     = 1'b1;
        ain       = reg_ctrl;
        din       = 8'h00;
        read      = 1'b0;
        write     = 1'b0;
        vram_din  = 8'h00;
        req_q     = 1'b0;
        want_addr = 14'h0000;
        addr_step = 14'd1;
        pal_check = 1'b0;
        bg_check  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // cpu vram writes, step 1 then step 32
        set_vram_addr(14'h2108);
        repeat (6) begin
            rnd = $random(seed);
            data_port_write(rnd[7:0]);
        end
        cpu_write(reg_ctrl, 8'h04);
        addr_step = 14'd32;
        repeat (6) begin
            rnd = $random(seed);
            data_port_write(rnd[7:0]);
        end
        cpu_write(reg_ctrl, 8'h00);
        addr_step = 14'd1;

        // palette entries 0 and 1, backdrop shows while rendering is off
        set_vram_addr(14'h3f00);
        rnd  = $random(seed);
        pal0 = rnd[5:0];
        data_port_write({2'b00, pal0});
        rnd  = $random(seed);
        pal1 = rnd[5:0];
        data_port_write({2'b00, pal1});
        repeat (4) next_cycle();
        pal_check = 1'b1;
        set_vram_addr(14'h3f04);
        data_port_write({2'b00, ~pal0});    // mirror slot, must be dropped
        repeat (4) next_cycle();
        pal_check = 1'b0;

        // vertical blank without and with nmi enabled
        wait_for_dot(9'd241, 9'd4);
        wait_for_dot(9'd0, 9'd0);
        cpu_write(reg_ctrl, 8'h80);
        wait_for_dot(9'd241, 9'd4);
        cpu_read(reg_status);
        repeat (2) next_cycle();
        cpu_write(reg_ctrl, 8'h00);

        // background rendering over three frames
        cpu_write(reg_mask, 8'h08);
        wait_for_dot(9'd511, 9'd0);
        wait_for_dot(9'd1, 9'd0);
        bg_check = 1'b1;
        repeat (3) begin
            wait_for_dot(9'd250, 9'd0);
            wait_for_dot(9'd1, 9'd0);
        end
        bg_check = 1'b0;

        $display("Test OK");
        $finish;
    end

endmodule

/* project.f */
logic/ppu_timing_pkg.sv
logic/ppu_reg_pkg.sv
logic/ppu_timing.sv
logic/ppu_regs.sv
logic/ppu_bg_fetch.sv
logic/ppu_bg_shifter.sv
logic/ppu_palette.sv
logic/ppu_top.sv
verification/ppu_tb.sv
